// File: vec_isa_pkg.sv
`default_nettype none

package vec_isa_pkg;

	localparam int word_bits     = 64;
	localparam int instr_bits    = 32;
	localparam int reg_count     = 32;
	localparam int reg_addr_bits = 5;
	localparam int imm_bits      = 16;

	// field positions counted from the instruction msb
	localparam int opcode_pos = 0;
	localparam int rd_pos     = 6;
	localparam int rs_pos     = 11;
	localparam int rt_pos     = 16;
	localparam int ppp_pos    = 21;
	localparam int ww_pos     = 24;
	localparam int funct_pos  = 26;
	localparam int imm_pos    = 16; // overlaps rt, ppp, ww, funct

	typedef logic [0:word_bits-1] word_t; // byte 0 is the msb byte

	typedef enum logic [5:0] {
		op_vld   = 6'b100000,
		op_vsd   = 6'b100001,
		op_rtype = 6'b101010
	} opcode_e; // anything else is a nop

	typedef enum logic [5:0] {
		f_and = 6'd0,
		f_or  = 6'd1,
		f_xor = 6'd2,
		f_not = 6'd3,
		f_mov = 6'd4,
		f_add = 6'd5,
		f_sub = 6'd6
	} funct_e;

	typedef enum logic [1:0] {w8, w16, w32, w64} lane_e;

	typedef enum logic [2:0] {
		p_all   = 3'd0,
		p_upper = 3'd1, // most significant 32 bits
		p_lower = 3'd2,
		p_even  = 3'd3, // bytes 0, 2, 4, 6
		p_odd   = 3'd4
	} ppp_e;

endpackage

`default_nettype wire

// File: vec_pipe_pkg.sv
`default_nettype none

package vec_pipe_pkg;

	localparam int addr_bits = 32;

	typedef struct packed {
		logic                                        wb_en;
		logic                                        use_alu; // 0 for a load
		vec_isa_pkg::funct_e                         funct;
		vec_isa_pkg::lane_e                          ww;
		vec_isa_pkg::ppp_e                           ppp;
		logic [vec_isa_pkg::reg_addr_bits-1:0]       rd;
		logic [vec_isa_pkg::reg_addr_bits-1:0]       rs;
		logic [vec_isa_pkg::reg_addr_bits-1:0]       rt;
		vec_isa_pkg::word_t                          rs_data; // load data rides here
		vec_isa_pkg::word_t                          rt_data;
	} ex_op_t;

	typedef struct packed {
		logic                                        en;
		logic [vec_isa_pkg::reg_addr_bits-1:0]       rd;
		vec_isa_pkg::ppp_e                           ppp;
		vec_isa_pkg::word_t                          data;
	} wb_t;

	typedef struct packed {
		logic                                        en;
		logic                                        wr_en;
		logic [addr_bits-1:0]                        addr;
		vec_isa_pkg::word_t                          wdata;
	} mem_req_t;

	function automatic vec_isa_pkg::word_t merge_ppp(input vec_isa_pkg::word_t old_data,
		input vec_isa_pkg::word_t new_data, input vec_isa_pkg::ppp_e ppp);
		vec_isa_pkg::word_t merged;
		int b;
		merged = old_data;
		for (b = 0; b < vec_isa_pkg::word_bits / 8; b++)
		begin
			if (ppp == vec_isa_pkg::p_all
				|| (ppp == vec_isa_pkg::p_upper && b < 4)
				|| (ppp == vec_isa_pkg::p_lower && b >= 4)
				|| (ppp == vec_isa_pkg::p_even && b % 2 == 0)
				|| (ppp == vec_isa_pkg::p_odd && b % 2 == 1))
				merged[8*b +: 8] = new_data[8*b +: 8];
		end
		return merged; // codes 5..7 leave old data
	endfunction

endpackage

`default_nettype wire

// File: vec_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module vec_fetch (
	input  wire logic                               clk,
	input  wire logic                               reset,
	input  wire logic                               stall,
	output logic [vec_pipe_pkg::addr_bits-1:0]      pc
);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc <= '0;
		end
		else if (!stall)
		begin
			pc <= pc + 1'b1; // word addressed
		end
		// held while stalled so the same word is refetched
	end

endmodule

`default_nettype wire

// File: vec_decode.sv
`timescale 1ns/1ns
`default_nettype none

module vec_decode (
	input  wire logic                                   clk,
	input  wire logic                                   reset,
	input  wire logic [0:vec_isa_pkg::instr_bits-1]     instruction,
	input  vec_isa_pkg::word_t                          mem_rdata,
	output logic [vec_isa_pkg::reg_addr_bits-1:0]       rd_addr_a,
	output logic [vec_isa_pkg::reg_addr_bits-1:0]       rd_addr_b,
	input  vec_isa_pkg::word_t                          rd_data_a,
	input  vec_isa_pkg::word_t                          rd_data_b,
	output logic                                        stall,
	output vec_pipe_pkg::mem_req_t                      mem_req,
	output vec_pipe_pkg::ex_op_t                        ex_op
);

	logic [0:vec_isa_pkg::instr_bits-1]     instr_q; // decode register
	logic                                   mem_wait; // second cycle of a load or store
	vec_isa_pkg::opcode_e                   opcode;
	logic [vec_isa_pkg::reg_addr_bits-1:0]  rd;
	logic [vec_isa_pkg::reg_addr_bits-1:0]  rs;
	logic [vec_isa_pkg::reg_addr_bits-1:0]  rt;
	logic [0:vec_isa_pkg::imm_bits-1]       imm;
	logic                                   is_ld;
	logic                                   is_sd;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			instr_q  <= '0; // opcode 0 is a nop
			mem_wait <= 1'b0;
		end
		else
		begin
			if (!stall)
				instr_q <= instruction;
			mem_wait <= stall;
		end
	end

	assign opcode = vec_isa_pkg::opcode_e'(instr_q[vec_isa_pkg::opcode_pos +: 6]);
	assign rd     = instr_q[vec_isa_pkg::rd_pos +: vec_isa_pkg::reg_addr_bits];
	assign rs     = instr_q[vec_isa_pkg::rs_pos +: vec_isa_pkg::reg_addr_bits];
	assign rt     = instr_q[vec_isa_pkg::rt_pos +: vec_isa_pkg::reg_addr_bits];
	assign imm    = instr_q[vec_isa_pkg::imm_pos +: vec_isa_pkg::imm_bits];
	assign is_ld  = (opcode == vec_isa_pkg::op_vld);
	assign is_sd  = (opcode == vec_isa_pkg::op_vsd);

	assign rd_addr_a = rs;
	assign rd_addr_b = is_sd ? rd : rt; // store data comes from rd
	assign stall     = (is_ld || is_sd) && !mem_wait;

	// load asks in its first cycle, store writes in its second
	assign mem_req.en    = (is_ld && !mem_wait) || (is_sd && mem_wait);
	assign mem_req.wr_en = is_sd && mem_wait;
	assign mem_req.addr  = {{(vec_pipe_pkg::addr_bits - vec_isa_pkg::imm_bits){1'b0}}, imm};
	assign mem_req.wdata = rd_data_b;

	always_comb
	begin
		ex_op = '0; // bubble unless something writes
		if (opcode == vec_isa_pkg::op_rtype)
		begin
			ex_op.wb_en   = 1'b1;
			ex_op.use_alu = 1'b1;
			ex_op.funct   = vec_isa_pkg::funct_e'(instr_q[vec_isa_pkg::funct_pos +: 6]);
			ex_op.ww      = vec_isa_pkg::lane_e'(instr_q[vec_isa_pkg::ww_pos +: 2]);
			ex_op.ppp     = vec_isa_pkg::ppp_e'(instr_q[vec_isa_pkg::ppp_pos +: 3]);
			ex_op.rd      = rd;
			ex_op.rs      = rs;
			ex_op.rt      = rt;
			ex_op.rs_data = rd_data_a;
			ex_op.rt_data = rd_data_b;
		end
		else if (is_ld && mem_wait)
		begin
			// rs/rt stay 0 so execute never forwards over the load data
			ex_op.wb_en   = 1'b1;
			ex_op.ppp     = vec_isa_pkg::p_all;
			ex_op.rd      = rd;
			ex_op.rs_data = mem_rdata;
		end
	end

endmodule

`default_nettype wire

// File: vec_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module vec_regfile (
	input  wire logic                                   clk,
	input  wire logic                                   reset,
	input  wire logic [vec_isa_pkg::reg_addr_bits-1:0]  rd_addr_a,
	input  wire logic [vec_isa_pkg::reg_addr_bits-1:0]  rd_addr_b,
	output vec_isa_pkg::word_t                          rd_data_a,
	output vec_isa_pkg::word_t                          rd_data_b,
	input  vec_pipe_pkg::wb_t                           wb
);

	vec_isa_pkg::word_t regs [0:vec_isa_pkg::reg_count-1];
	vec_isa_pkg::word_t wr_merged;
	logic               wr_en;

	assign wr_en     = wb.en && (wb.rd != '0); // r0 never written
	assign wr_merged = vec_pipe_pkg::merge_ppp(regs[wb.rd], wb.data, wb.ppp);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int k = 0; k < vec_isa_pkg::reg_count; k++)
				regs[k] <= '0;
		end
		else if (wr_en)
		begin
			regs[wb.rd] <= wr_merged;
		end
	end

	// same-cycle write shows up on the read ports
	assign rd_data_a = (wr_en && wb.rd == rd_addr_a) ? wr_merged : regs[rd_addr_a];
	assign rd_data_b = (wr_en && wb.rd == rd_addr_b) ? wr_merged : regs[rd_addr_b];

endmodule

`default_nettype wire

// File: vec_alu.sv
`timescale 1ns/1ns
`default_nettype none

module vec_alu (
	input  vec_isa_pkg::funct_e     funct,
	input  vec_isa_pkg::lane_e      ww,
	input  vec_isa_pkg::word_t      a,
	input  vec_isa_pkg::word_t      b,
	output vec_isa_pkg::word_t      result
);

	localparam int n_bytes = vec_isa_pkg::word_bits / 8;

	logic [0:n_bytes-1]  lane_lsb; // set on the last byte of each lane
	vec_isa_pkg::word_t  arith;
	logic                is_sub;

	assign is_sub = (funct == vec_isa_pkg::f_sub);

	always_comb
	begin
		case (ww)
			vec_isa_pkg::w8:  lane_lsb = 8'b1111_1111;
			vec_isa_pkg::w16: lane_lsb = 8'b0101_0101;
			vec_isa_pkg::w32: lane_lsb = 8'b0001_0001;
			default:          lane_lsb = 8'b0000_0001;
		endcase
	end

	// byte-serial ripple with the carry restarting at each lane boundary
	always_comb
	begin
		vec_isa_pkg::word_t b_in;
		logic               carry;
		logic [8:0]         sum;
		int                 i;
		b_in  = is_sub ? ~b : b; // subtract as a + ~b + 1
		carry = 1'b0;
		for (i = n_bytes - 1; i >= 0; i--)
		begin
			if (lane_lsb[i])
				carry = is_sub;
			sum = {1'b0, a[8*i +: 8]} + {1'b0, b_in[8*i +: 8]} + {8'b0, carry};
			arith[8*i +: 8] = sum[7:0];
			carry = sum[8]; // dropped when the lane ends
		end
	end

	always_comb
	begin
		case (funct)
			vec_isa_pkg::f_and: result = a & b;
			vec_isa_pkg::f_or:  result = a | b;
			vec_isa_pkg::f_xor: result = a ^ b;
			vec_isa_pkg::f_not: result = ~a;
			vec_isa_pkg::f_mov: result = a;
			vec_isa_pkg::f_add,
			vec_isa_pkg::f_sub: result = arith;
			default:            result = '0; // unknown funct
		endcase
	end

endmodule

`default_nettype wire

// File: vec_execute.sv
`timescale 1ns/1ns
`default_nettype none

module vec_execute (
	input  wire logic               clk,
	input  wire logic               reset,
	input  vec_pipe_pkg::ex_op_t    ex_op,
	output vec_pipe_pkg::wb_t       wb
);

	vec_pipe_pkg::ex_op_t   ex_q;
	vec_isa_pkg::word_t     op_a;
	vec_isa_pkg::word_t     op_b;
	vec_isa_pkg::word_t     alu_result;
	logic                   fwd_a;
	logic                   fwd_b;

	always_ff @(posedge clk)
	begin
		if (reset)
			ex_q.wb_en <= 1'b0;
		else
			ex_q <= ex_op;
	end

	// write-back result is one instruction ahead
	assign fwd_a = wb.en && (wb.rd != '0) && (wb.rd == ex_q.rs);
	assign fwd_b = wb.en && (wb.rd != '0) && (wb.rd == ex_q.rt);

	// a partial write only replaces part of the operand
	assign op_a = fwd_a ? vec_pipe_pkg::merge_ppp(ex_q.rs_data, wb.data, wb.ppp)
		: ex_q.rs_data;
	assign op_b = fwd_b ? vec_pipe_pkg::merge_ppp(ex_q.rt_data, wb.data, wb.ppp)
		: ex_q.rt_data;

	vec_alu i_vec_alu (
		.funct  (ex_q.funct),
		.ww     (ex_q.ww),
		.a      (op_a),
		.b      (op_b),
		.result (alu_result)
	);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wb.en <= 1'b0;
		end
		else
		begin
			wb.en   <= ex_q.wb_en;
			wb.rd   <= ex_q.rd;
			wb.ppp  <= ex_q.ppp;
			wb.data <= ex_q.use_alu ? alu_result : ex_q.rs_data; // load data unmodified
		end
	end

endmodule

`default_nettype wire

// File: vec_core.sv
`timescale 1ns/1ns
`default_nettype none

module vec_core (
	input  wire logic                                   clk,
	input  wire logic                                   reset,
	input  wire logic [0:vec_isa_pkg::instr_bits-1]     instruction,
	output logic [vec_pipe_pkg::addr_bits-1:0]          pc,
	input  vec_isa_pkg::word_t                          mem_rdata,
	output vec_pipe_pkg::mem_req_t                      mem_req
);

	logic                                   stall;
	logic [vec_isa_pkg::reg_addr_bits-1:0]  rd_addr_a;
	logic [vec_isa_pkg::reg_addr_bits-1:0]  rd_addr_b;
	vec_isa_pkg::word_t                     rd_data_a;
	vec_isa_pkg::word_t                     rd_data_b;
	vec_pipe_pkg::ex_op_t                   ex_op;
	vec_pipe_pkg::wb_t                      wb; // regfile write port and forward source

	vec_fetch i_vec_fetch (
		.clk   (clk),
		.reset (reset),
		.stall (stall),
		.pc    (pc)
	);

	vec_decode i_vec_decode (
		.clk         (clk),
		.reset       (reset),
		.instruction (instruction),
		.mem_rdata   (mem_rdata),
		.rd_addr_a   (rd_addr_a),
		.rd_addr_b   (rd_addr_b),
		.rd_data_a   (rd_data_a),
		.rd_data_b   (rd_data_b),
		.stall       (stall),
		.mem_req     (mem_req),
		.ex_op       (ex_op)
	);

	vec_regfile i_vec_regfile (
		.clk       (clk),
		.reset     (reset),
		.rd_addr_a (rd_addr_a),
		.rd_addr_b (rd_addr_b),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.wb        (wb)
	);

	vec_execute i_vec_execute (
		.clk   (clk),
		.reset (reset),
		.ex_op (ex_op),
		.wb    (wb)
	);

endmodule

`default_nettype wire

// File: vec_core_properties.sv
`timescale 1ns/1ns
`default_nettype none

module vec_core_properties (
	input  wire logic                               clk,
	input  wire logic                               reset,
	input  wire logic [vec_pipe_pkg::addr_bits-1:0] pc,
	input  vec_pipe_pkg::mem_req_t                  mem_req
);

	// a write is always a request
	assert property (@(posedge clk) disable iff (reset) mem_req.wr_en |-> mem_req.en)
	else $error("mem_req.wr_en high without mem_req.en");

	assert property (@(posedge clk) reset |=> !mem_req.en && !mem_req.wr_en)
	else $error("memory request active in the cycle after reset");

	// fetch holds during the load stall
	assert property (@(posedge clk) disable iff (reset)
		mem_req.en && !mem_req.wr_en |=> $stable(pc))
	else $error("pc moved at the edge after a load request");

endmodule

bind vec_core vec_core_properties i_vec_core_properties (
	.clk     (clk),
	.reset   (reset),
	.pc      (pc),
	.mem_req (mem_req)
);

`default_nettype wire

// File: tb_vec_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_vec_core;

	localparam int body_len    = 40; // random instructions in a test body
	localparam int max_prog    = 8 + body_len + 33;
	localparam int n_tests     = 5;
	localparam int watchdog_ns = n_tests * max_prog * 3 * 20 + 2000;

	logic                    clk;
	logic                    reset;
	logic [31:0]             instruction;
	logic [31:0]             pc;
	logic [63:0]             mem_rdata;
	vec_pipe_pkg::mem_req_t  mem_req;

	logic [31:0] imem [0:255];
	logic [63:0] dmem [0:255];
	logic [63:0] ref_regs [0:31];
	logic [63:0] ref_mem [0:255];
	logic [15:0] exp_addr [$];
	logic [63:0] exp_data [$];
	logic [31:0] lfsr = 32'd74022;
	logic [31:0] touched; // registers written by the program
	int          prog_len;
	int          errors;
	int          checked;
	logic        rd_pending;
	logic [7:0]  rd_pending_addr;

	vec_core i_vec_core (
		.clk         (clk),
		.reset       (reset),
		.instruction (instruction),
		.pc          (pc),
		.mem_rdata   (mem_rdata),
		.mem_req     (mem_req)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [63:0] rand_bits(int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v    = {v[62:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1); // galois step
		end
		return v;
	endfunction

	function automatic logic [4:0] rand_reg(int bits);
		return 5'(rand_bits(bits));
	endfunction

	function automatic logic [63:0] merge_ref(logic [63:0] old_v, logic [63:0] new_v,
		logic [2:0] ppp);
		logic [63:0] mask;
		case (ppp)
			vec_isa_pkg::p_all:   mask = '1;
			vec_isa_pkg::p_upper: mask = 64'hffff_ffff_0000_0000;
			vec_isa_pkg::p_lower: mask = 64'h0000_0000_ffff_ffff;
			vec_isa_pkg::p_even:  mask = 64'hff00_ff00_ff00_ff00; // byte 0 is the msb byte
			vec_isa_pkg::p_odd:   mask = 64'h00ff_00ff_00ff_00ff;
			default:              mask = '0;
		endcase
		return (old_v & ~mask) | (new_v & mask);
	endfunction

	function automatic logic [63:0] alu_ref(logic [5:0] fn, logic [1:0] ww, logic [63:0] a,
		logic [63:0] b);
		logic [63:0] mask;
		logic [63:0] res;
		int          w;
		w    = 8 << ww;
		mask = {64{1'b1}} >> (64 - w);
		res  = '0;
		case (fn)
			vec_isa_pkg::f_and: res = a & b;
			vec_isa_pkg::f_or:  res = a | b;
			vec_isa_pkg::f_xor: res = a ^ b;
			vec_isa_pkg::f_not: res = ~a;
			vec_isa_pkg::f_mov: res = a;
			vec_isa_pkg::f_add,
			vec_isa_pkg::f_sub:
				for (int k = 0; k < 64; k += w)
					res |= (((fn == vec_isa_pkg::f_add) ? (a >> k) + (b >> k)
						: (a >> k) - (b >> k)) & mask) << k; // each lane wraps alone
			default: res = '0;
		endcase
		return res;
	endfunction

	function automatic void run_reference();
		logic [31:0] ins;
		for (int r = 0; r < 32; r++)
			ref_regs[r] = '0;
		for (int a = 0; a < 256; a++)
			ref_mem[a] = dmem[a];
		for (int i = 0; i < prog_len; i++)
		begin
			ins = imem[i];
			if (ins[31:26] == vec_isa_pkg::op_rtype)
				ref_regs[ins[25:21]] = merge_ref(ref_regs[ins[25:21]], alu_ref(ins[5:0],
					ins[7:6], ref_regs[ins[20:16]], ref_regs[ins[15:11]]), ins[10:8]);
			else if (ins[31:26] == vec_isa_pkg::op_vld)
				ref_regs[ins[25:21]] = ref_mem[ins[7:0]];
			else if (ins[31:26] == vec_isa_pkg::op_vsd)
			begin
				exp_addr.push_back(ins[15:0]);
				exp_data.push_back(ref_regs[ins[25:21]]);
				ref_mem[ins[7:0]] = ref_regs[ins[25:21]];
			end
			ref_regs[0] = '0; // r0 reads zero
		end
	endfunction

	task automatic report_mismatch(string sig, logic [63:0] expected, logic [63:0] actual);
		$display("error at %0t ns: %s expected %h, got %h", $time, sig, expected, actual);
		errors++;
	endtask

	task automatic emit_instr(logic [5:0] op, logic [4:0] rd, logic [4:0] rs, logic [15:0] low);
		imem[prog_len] = {op, rd, rs, low};
		prog_len++;
		if (op != vec_isa_pkg::op_vsd)
			touched[rd] = 1'b1;
	endtask

	task automatic emit_alu(logic [5:0] fn, logic [2:0] ppp, logic [1:0] ww, logic [4:0] rd,
		logic [4:0] rs, logic [4:0] rt);
		emit_instr(vec_isa_pkg::op_rtype, rd, rs, {rt, ppp, ww, fn});
	endtask

	task automatic begin_program();
		prog_len = 0;
		touched  = '0;
		for (int a = 0; a < 256; a++)
		begin
			imem[a] = '0; // nop
			dmem[a] = {4{a[7:0], ~a[7:0]}};
		end
		for (int a = 0; a < 8; a++)
			dmem[a] = rand_bits(64);
		for (int r = 1; r <= 8; r++)
			emit_instr(vec_isa_pkg::op_vld, 5'(r), 5'd0, 16'(r - 1));
	endtask

	task automatic run_test(string name);
		int errors_before;
		int checked_before;
		int cycles;
		errors_before  = errors;
		checked_before = checked;
		for (int r = 0; r < 32; r++)
			if (touched[r])
				emit_instr(vec_isa_pkg::op_vsd, 5'(r), 5'd0, 16'(100 + r));
		run_reference();
		repeat (10)
		begin
			@(negedge clk);
			assert (!mem_req.en && !mem_req.wr_en)
			else report_mismatch("mem_req.en/wr_en", 0, 64'({mem_req.en, mem_req.wr_en}));
		end
		assert (pc == 0) else report_mismatch("pc", 0, 64'(pc));
		reset  <= 1'b0;
		cycles = 0;
		while (exp_addr.size() > 0 && cycles < prog_len * 3 + 20)
		begin
			@(negedge clk);
			cycles++;
		end
		if (exp_addr.size() > 0)
		begin
			$display("test %s: %0d expected stores never appeared", name, exp_addr.size());
			errors += exp_addr.size();
			exp_addr.delete();
			exp_data.delete();
		end
		$display("test %s: %0d stores checked, %0d errors", name, checked - checked_before,
			errors - errors_before);
		reset <= 1'b1; // held until the next test releases it
	endtask

	// instruction and data memory models
	always @(negedge clk)
	begin
		instruction <= (pc < 256) ? imem[pc[7:0]] : '0;
		if (rd_pending)
			mem_rdata <= dmem[rd_pending_addr]; // one cycle after the request
		rd_pending      <= mem_req.en && !mem_req.wr_en && !reset;
		rd_pending_addr <= mem_req.addr[7:0];
		if (!reset && mem_req.wr_en)
			dmem[mem_req.addr[7:0]] <= mem_req.wdata;
	end

	always @(negedge clk)
	begin
		if (!reset && mem_req.wr_en)
		begin
			if (exp_addr.size() == 0)
			begin
				$display("unexpected store to address %0d at %0t ns", mem_req.addr, $time);
				errors++;
			end
			else
			begin
				assert (mem_req.addr == 32'(exp_addr[0]))
				else report_mismatch("mem_req.addr", 64'(exp_addr[0]), 64'(mem_req.addr));
				assert (mem_req.wdata == exp_data[0])
				else report_mismatch("mem_req.wdata", exp_data[0], mem_req.wdata);
				void'(exp_addr.pop_front());
				void'(exp_data.pop_front());
				checked++;
			end
		end
	end

	initial
	begin
		#(watchdog_ns);
		$display("timeout after %0d ns, the tests did not finish", watchdog_ns);
		$display("Verification failed");
		$finish;
	end

	initial
	begin
		reset       = 1'b1;
		instruction = '0;
		mem_rdata   = '0;
		rd_pending  = 1'b0;
		errors      = 0;
		checked     = 0;
		begin_program();
		emit_instr(vec_isa_pkg::op_vsd, 5'd0, 5'd0, 16'd99); // r0 stores as zero
		run_test("load_store");
		begin_program();
		repeat (body_len)
			emit_alu(6'(rand_bits(3) % 5), vec_isa_pkg::p_all, 2'(rand_bits(2)),
				rand_reg(4), rand_reg(4), rand_reg(4));
		run_test("logic");
		begin_program();
		emit_alu(vec_isa_pkg::f_not, vec_isa_pkg::p_all, vec_isa_pkg::w64, 5'd9, 5'd0, 5'd0);
		for (int w = 0; w < 4; w++)
		begin
			emit_alu(vec_isa_pkg::f_add, vec_isa_pkg::p_all, 2'(w), 5'(10 + w), 5'd9, 5'(1 + w));
			emit_alu(vec_isa_pkg::f_sub, vec_isa_pkg::p_all, 2'(w), 5'(14 + w), 5'd0, 5'(5 + w));
			emit_alu(6'(5 + rand_bits(1)), vec_isa_pkg::p_all, 2'(w), 5'(18 + w),
				rand_reg(3), rand_reg(3));
		end
		run_test("lane_arith");
		begin_program();
		for (int p = 0; p < 5; p++)
		begin
			emit_alu(vec_isa_pkg::f_xor, 3'(p), vec_isa_pkg::w64, 5'(1 + p), 5'(1 + p), 5'd7);
			emit_alu(vec_isa_pkg::f_mov, 3'(p), vec_isa_pkg::w64, 5'(10 + p), 5'd8, 5'd0);
		end
		run_test("partial");
		begin_program();
		repeat (body_len)
		begin
			case (rand_bits(2))
				0: emit_instr(vec_isa_pkg::op_vld, rand_reg(2), 5'd0, 16'(rand_bits(3)));
				1: emit_instr(vec_isa_pkg::op_vsd, rand_reg(2), 5'd0, 16'(200 + rand_bits(4)));
				default: emit_alu(6'(rand_bits(3)), 3'(rand_bits(3)), 2'(rand_bits(2)),
					rand_reg(2), rand_reg(2), rand_reg(2));
			endcase
		end
		run_test("dependency");
		$display("tests %0d, stores checked %0d, errors %0d", n_tests, checked, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
vec_isa_pkg.sv
vec_pipe_pkg.sv
vec_fetch.sv
vec_decode.sv
vec_regfile.sv
vec_alu.sv
vec_execute.sv
vec_core.sv
vec_core_properties.sv
tb_vec_core.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_vec_core -f src.f -o sim_vec_core
./obj_dir/sim_vec_core | tee sim.log
if grep -q "Verification passed" sim.log; then
	echo "simulation run: PASS"
else
	echo "simulation run: FAIL"
	exit 1
fi
